// ==== logic/lsab_pkg.sv ====
package lsab_pkg;

  // Defaults only. The top level passes its own values down.
  parameter int LSAB_CHANNELS = 4;
  parameter int LSAB_DEPTH = 16; // Must be a power of two.

  typedef logic [31:0] lsab_word_t;
  typedef logic [24:0] lsab_ancill_t;
  typedef logic [1:0] lsab_section_t;

  // One stored word with its tag and interrupt mark.
  typedef struct packed {
    logic irq;
    lsab_ancill_t ancill;
    lsab_word_t word;
  } lsab_entry_t;

  // What a device presents on its channel in one cycle.
  // An irq without wr marks the next word written on that channel.
  typedef struct packed {
    logic wr;
    logic irq;
    lsab_ancill_t ancill;
    lsab_word_t word;
  } lsab_write_t;

endpackage

// ==== logic/mvblck_pkg.sv ====
package mvblck_pkg;

  import lsab_pkg::*;

  typedef logic [8:0] mvblck_col_t; // Word address, wraps at 512.
  typedef logic [5:0] mvblck_count_t;

  // Block command as issued by the host.
  typedef struct packed {
    mvblck_col_t start;
    mvblck_count_t count;
    lsab_section_t section;
  } mvblck_cmd_t;

  // Everything but working holds until the next accepted issue.
  typedef struct packed {
    logic working;
    logic irq;
    logic abrupt_stop;
    mvblck_count_t count_sent;
    lsab_ancill_t ancill;
  } mvblck_status_t;

  typedef enum logic [1:0] {
    mv_idle,
    mv_fetch,
    mv_write,
    mv_done
  } mvblck_state_t;

  // Wishbone classic master outputs, single writes only.
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    mvblck_col_t adr;
    lsab_word_t dat;
    logic [3:0] sel;
  } wb_master_t;

endpackage

// ==== logic/lsab_ingress.sv ====
`timescale 1ns/1ns

module lsab_ingress
  import lsab_pkg::*;
#(
  parameter int LSAB_CHANNELS = lsab_pkg::LSAB_CHANNELS
)
(
  input  logic                     CLK_n,
  input  logic                     RST_MASTER,
  input  lsab_write_t              i_dev [LSAB_CHANNELS],
  output logic [LSAB_CHANNELS-1:0] o_push,
  output lsab_entry_t              o_entry [LSAB_CHANNELS]
);

  // Interrupt seen on a channel with no word to carry it yet.
  logic [LSAB_CHANNELS-1:0] pending_q;

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      o_push <= '0;
      pending_q <= '0;
    end
    else
    begin
      for (int c = 0; c < LSAB_CHANNELS; c++)
      begin
        o_push[c] <= i_dev[c].wr;
        if (i_dev[c].wr)
          pending_q[c] <= 1'b0; // The mark leaves with this word.
        else if (i_dev[c].irq)
          pending_q[c] <= 1'b1;
      end
    end
  end

  // The entry only changes with a write, so it is stable while push is low.
  always_ff @(posedge CLK_n)
  begin
    for (int c = 0; c < LSAB_CHANNELS; c++)
    begin
      if (i_dev[c].wr)
      begin
        o_entry[c].irq <= i_dev[c].irq | pending_q[c];
        o_entry[c].ancill <= i_dev[c].ancill;
        o_entry[c].word <= i_dev[c].word;
      end
    end
  end

endmodule

// ==== logic/lsab_section.sv ====
`timescale 1ns/1ns

module lsab_section
  import lsab_pkg::*;
#(
  parameter int LSAB_DEPTH = lsab_pkg::LSAB_DEPTH
)
(
  input  logic        CLK_n,
  input  logic        RST_MASTER,
  input  logic        i_push,
  input  lsab_entry_t i_entry,
  input  logic        i_pop,
  output lsab_entry_t o_head,
  output logic        o_empty,
  output logic        o_full
);

  localparam int PTR_W = $clog2(LSAB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  lsab_entry_t mem_q [LSAB_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic do_push;
  logic do_pop;

  assign do_push = i_push && (count_q != CNT_W'(LSAB_DEPTH));
  assign do_pop = i_pop && !o_empty;

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1; // Pointers wrap with the power-of-two depth.
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= i_entry;
  end

  assign o_head = mem_q[rd_ptr_q];
  assign o_empty = (count_q == '0);

  // One slot stays free for the word still in the ingress register.
  assign o_full = (count_q >= CNT_W'(LSAB_DEPTH - 1));

endmodule

// ==== logic/mvblck_todram.sv ====
`timescale 1ns/1ns

module mvblck_todram
  import lsab_pkg::*;
  import mvblck_pkg::*;
#(
  parameter int LSAB_CHANNELS = lsab_pkg::LSAB_CHANNELS
)
(
  input  logic                     CLK_n,
  input  logic                     RST_MASTER,
  input  mvblck_cmd_t              i_cmd,
  input  logic                     i_issue,
  input  lsab_entry_t              i_head [LSAB_CHANNELS],
  input  logic [LSAB_CHANNELS-1:0] i_empty,
  output logic [LSAB_CHANNELS-1:0] o_pop,
  output wb_master_t               o_wb,
  input  logic                     i_wb_ack,
  output mvblck_status_t           o_status
);

  mvblck_state_t state_q;
  mvblck_cmd_t cmd_q;
  lsab_entry_t word_q; // Word on the bus, with its mark and tag.
  mvblck_col_t adr_q;
  logic cyc_q;
  logic irq_q;
  logic abrupt_q;
  mvblck_count_t count_sent_q;
  lsab_ancill_t ancill_q;

  lsab_entry_t sel_head;
  logic sel_empty;
  logic issue_ok;
  logic pop_ok;
  mvblck_count_t count_next;
  logic last_word;

  assign sel_head = i_head[cmd_q.section];
  assign sel_empty = i_empty[cmd_q.section];
  assign issue_ok = (state_q == mv_idle) && i_issue; // Issues while busy are dropped.
  assign pop_ok = (state_q == mv_fetch) && !sel_empty;
  assign count_next = count_sent_q + 1'b1;
  assign last_word = (count_next == cmd_q.count);

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      state_q <= mv_idle;
      cyc_q <= 1'b0;
      irq_q <= 1'b0;
      abrupt_q <= 1'b0;
      count_sent_q <= '0;
      ancill_q <= '0;
    end
    else
    begin
      unique case (state_q)
        mv_idle:
        begin
          if (i_issue)
          begin
            irq_q <= 1'b0;
            abrupt_q <= 1'b0;
            count_sent_q <= '0;
            ancill_q <= '0;
            // An empty request ends without touching the bus.
            state_q <= (i_cmd.count == '0) ? mv_done : mv_fetch;
          end
        end
        mv_fetch:
        begin
          if (sel_empty)
          begin
            abrupt_q <= 1'b1;
            state_q <= mv_done;
          end
          else
          begin
            cyc_q <= 1'b1;
            state_q <= mv_write;
          end
        end
        mv_write:
        begin
          if (i_wb_ack)
          begin
            cyc_q <= 1'b0;
            count_sent_q <= count_next;
            if (word_q.irq)
            begin
              irq_q <= 1'b1;
              ancill_q <= word_q.ancill;
            end
            state_q <= (last_word || word_q.irq) ? mv_done : mv_fetch;
          end
        end
        mv_done:
          state_q <= mv_idle;
      endcase
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (issue_ok)
      cmd_q <= i_cmd;
    if (pop_ok)
    begin
      word_q <= sel_head;
      adr_q <= cmd_q.start + mvblck_col_t'(count_sent_q); // Wraps from 511 to 0.
    end
  end

  always_comb
  begin
    o_pop = '0;
    if (pop_ok)
      o_pop[cmd_q.section] = 1'b1;
  end

  // All fields come from registers, so they hold while ack is awaited.
  always_comb
  begin
    o_wb.cyc = cyc_q;
    o_wb.stb = cyc_q;
    o_wb.we = 1'b1;
    o_wb.adr = adr_q;
    o_wb.dat = word_q.word;
    o_wb.sel = 4'hf;
  end

  always_comb
  begin
    o_status.working = (state_q != mv_idle);
    o_status.irq = irq_q;
    o_status.abrupt_stop = abrupt_q;
    o_status.count_sent = count_sent_q;
    o_status.ancill = ancill_q;
  end

endmodule

// ==== logic/lsab_fill_core.sv ====
`timescale 1ns/1ns

module lsab_fill_core
  import lsab_pkg::*;
  import mvblck_pkg::*;
#(
  parameter int LSAB_CHANNELS = lsab_pkg::LSAB_CHANNELS,
  parameter int LSAB_DEPTH = lsab_pkg::LSAB_DEPTH
)
(
  input  logic                     CLK_n,
  input  logic                     RST_MASTER,
  input  lsab_write_t              i_dev [LSAB_CHANNELS],
  output logic [LSAB_CHANNELS-1:0] o_dev_full,
  input  mvblck_cmd_t              i_cmd,
  input  logic                     i_issue,
  output mvblck_status_t           o_status,
  output wb_master_t               o_wb,
  input  logic                     i_wb_ack
);

  logic [LSAB_CHANNELS-1:0] w_push;
  lsab_entry_t w_entry [LSAB_CHANNELS];
  lsab_entry_t w_head [LSAB_CHANNELS];
  logic [LSAB_CHANNELS-1:0] w_empty;
  logic [LSAB_CHANNELS-1:0] w_pop;

  lsab_ingress #(
    .LSAB_CHANNELS(LSAB_CHANNELS)
  ) u_ingress (
    .CLK_n(CLK_n),
    .RST_MASTER(RST_MASTER),
    .i_dev(i_dev),
    .o_push(w_push),
    .o_entry(w_entry)
  );

  // Each section's full flag goes straight back to its producer.
  for (genvar g = 0; g < LSAB_CHANNELS; g++)
  begin : g_section
    lsab_section #(
      .LSAB_DEPTH(LSAB_DEPTH)
    ) u_section (
      .CLK_n(CLK_n),
      .RST_MASTER(RST_MASTER),
      .i_push(w_push[g]),
      .i_entry(w_entry[g]),
      .i_pop(w_pop[g]),
      .o_head(w_head[g]),
      .o_empty(w_empty[g]),
      .o_full(o_dev_full[g])
    );
  end

  mvblck_todram #(
    .LSAB_CHANNELS(LSAB_CHANNELS)
  ) u_mover (
    .CLK_n(CLK_n),
    .RST_MASTER(RST_MASTER),
    .i_cmd(i_cmd),
    .i_issue(i_issue),
    .i_head(w_head),
    .i_empty(w_empty),
    .o_pop(w_pop),
    .o_wb(o_wb),
    .i_wb_ack(i_wb_ack),
    .o_status(o_status)
  );

endmodule

// ==== tests/lsab_fill_core_assert.sv ====
`timescale 1ns/1ns

module lsab_fill_core_assert
  import lsab_pkg::*;
  import mvblck_pkg::*;
#(
  parameter int LSAB_CHANNELS = lsab_pkg::LSAB_CHANNELS
)
(
  input logic                     CLK_n,
  input logic                     RST_MASTER,
  input lsab_write_t              i_dev [LSAB_CHANNELS],
  input logic [LSAB_CHANNELS-1:0] i_dev_full,
  input mvblck_status_t           i_status,
  input wb_master_t               i_wb,
  input logic                     i_wb_ack
);

  // Address and data must not move until the slave has taken the word.
  a_bus_hold: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    (i_wb.stb && !i_wb_ack) |=> (i_wb.stb && $stable(i_wb)))
    else $error("Wishbone fields changed before ack");

  a_stb_cyc: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    !(i_wb.stb && !i_wb.cyc))
    else $error("stb high without cyc");

  a_reset_idle: assert property (@(posedge CLK_n) RST_MASTER |=> !i_status.working)
    else $error("mover working in the cycle after reset");

  for (genvar g = 0; g < LSAB_CHANNELS; g++)
  begin : g_full
    a_no_write_full: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
      i_dev[g].wr |-> !i_dev_full[g])
      else $error("write strobe on channel %0d while its section is full", g);
  end

endmodule

bind lsab_fill_core lsab_fill_core_assert #(
  .LSAB_CHANNELS(LSAB_CHANNELS)
) u_assert (
  .CLK_n(CLK_n),
  .RST_MASTER(RST_MASTER),
  .i_dev(i_dev),
  .i_dev_full(o_dev_full),
  .i_status(o_status),
  .i_wb(o_wb),
  .i_wb_ack(i_wb_ack)
);

// ==== tests/tb_lsab_fill_core.sv ====
`timescale 1ns/1ns

module tb_lsab_fill_core
  import lsab_pkg::*;
  import mvblck_pkg::*;
();

  localparam int CHANNELS = 4;
  localparam int DEPTH = 16;

  logic CLK_n = 1'b0;
  logic RST_MASTER;
  lsab_write_t dev [CHANNELS];
  logic [CHANNELS-1:0] dev_full;
  mvblck_cmd_t cmd;
  logic issue;
  mvblck_status_t status;
  wb_master_t wb;
  logic wb_ack;

  lsab_word_t mem [512];
  mvblck_col_t col_log [$]; // Columns in the order they were written.
  lsab_word_t model_q [CHANNELS][$]; // Words written and not yet moved.
  logic ack_busy;
  int unsigned ack_wait;

  lsab_fill_core #(
    .LSAB_CHANNELS(CHANNELS),
    .LSAB_DEPTH(DEPTH)
  ) u_dut (
    .CLK_n(CLK_n),
    .RST_MASTER(RST_MASTER),
    .i_dev(dev),
    .o_dev_full(dev_full),
    .i_cmd(cmd),
    .i_issue(issue),
    .o_status(status),
    .o_wb(wb),
    .i_wb_ack(wb_ack)
  );

  always #50 CLK_n = ~CLK_n;

  // Memory slave. Ack follows the strobe after 0 to 3 cycles and lasts one cycle.
  always @(negedge CLK_n)
  begin
    if (wb_ack)
      wb_ack = 1'b0;
    else if (wb.cyc && wb.stb)
    begin
      if (!ack_busy)
      begin
        ack_busy = 1'b1;
        ack_wait = $urandom % 4;
      end
      if (ack_wait == 0)
      begin
        check_access(wb, "bus access");
        mem[wb.adr] = wb.dat;
        col_log.push_back(wb.adr);
        ack_busy = 1'b0;
        wb_ack = 1'b1;
      end
      else
        ack_wait--;
    end
  end

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(lsab_word_t got, lsab_word_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_col(mvblck_col_t got, mvblck_col_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[ERROR] time %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_full(logic [CHANNELS-1:0] got, logic [CHANNELS-1:0] exp, string what);
    if (got !== exp)
      stop_run($sformatf("[ERROR] time %0t: %s are %b, expected %b", $time, what, got, exp));
  endtask

  // Every bus cycle must be a single write with all four bytes selected.
  task automatic check_access(wb_master_t got, string what);
    if (got.we !== 1'b1 || got.sel !== 4'hf)
      stop_run($sformatf("[ERROR] time %0t: %s has we %b sel %h, expected we 1 sel f",
        $time, what, got.we, got.sel));
  endtask

  task automatic check_status(mvblck_status_t got, mvblck_status_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[ERROR] time %0t: %s is sent %0d irq %b abrupt %b tag %h, %s",
        $time, what, got.count_sent, got.irq, got.abrupt_stop, got.ancill,
        $sformatf("expected sent %0d irq %b abrupt %b tag %h", exp.count_sent, exp.irq,
          exp.abrupt_stop, exp.ancill)));
  endtask

  task automatic write_word(int ch, lsab_word_t w, lsab_ancill_t tag, logic mark);
    if (dev_full[ch])
      stop_run($sformatf("channel %0d is full, the stimulus writes more words than fit", ch));
    if (mark)
    begin
      dev[ch].irq = 1'b1; // Lone strobe, the ingress keeps it for the word below.
      @(negedge CLK_n);
      dev[ch].irq = 1'b0;
    end
    dev[ch].wr = 1'b1;
    dev[ch].ancill = tag;
    dev[ch].word = w;
    @(negedge CLK_n);
    dev[ch].wr = 1'b0;
    model_q[ch].push_back(w);
  endtask

  task automatic run_block(mvblck_cmd_t c, mvblck_status_t exp);
    int unsigned limit;
    int unsigned cycles;
    mvblck_col_t col;
    lsab_word_t w;
    limit = 8 * c.count + 20;
    cycles = 0;
    repeat (2) @(negedge CLK_n); // Last written words reach their section.
    col_log.delete();
    cmd = c;
    issue = 1'b1;
    @(negedge CLK_n);
    issue = 1'b0;
    while (status.working)
    begin
      @(negedge CLK_n);
      cycles++;
      if (cycles > limit)
        stop_run($sformatf("timeout, block on section %0d still busy after %0d cycles",
          c.section, cycles));
    end
    check_status(status, exp, "block status");
    if (col_log.size() != int'(exp.count_sent))
      stop_run($sformatf("block at column %0d made %0d memory writes instead of %0d",
        c.start, col_log.size(), exp.count_sent));
    for (int i = 0; i < col_log.size(); i++)
    begin
      col = mvblck_col_t'((int'(c.start) + i) % 512); // Memory has 512 columns.
      w = model_q[c.section].pop_front();
      check_col(col_log[i], col, "write column");
      check_word(mem[col], w, "memory word");
    end
  endtask

  initial
  begin
    int fd;
    int n;
    string line;
    logic [7:0] op;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6;
    mvblck_cmd_t c;
    mvblck_status_t exp;
    void'($urandom(32'hc4ba));
    RST_MASTER = 1'b1;
    cmd = '0;
    issue = 1'b0;
    wb_ack = 1'b0;
    ack_busy = 1'b0;
    ack_wait = 0;
    for (int i = 0; i < CHANNELS; i++)
      dev[i] = '0;
    fd = $fopen("tests/fill_stimulus.txt", "r");
    if (fd == 0)
      stop_run("cannot open the stimulus file tests/fill_stimulus.txt");
    repeat (2) @(negedge CLK_n);
    RST_MASTER = 1'b0;
    @(negedge CLK_n);
    if (wb.cyc || wb.stb)
      stop_run("Wishbone cycle active right after reset");
    check_status(status, '0, "status after reset");
    check_full(dev_full, '0, "full bits after reset");
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n < 2 || line[0] == "#")
        continue;
      op = line[0];
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
        f0, f1, f2, f3, f4, f5, f6);
      case (op)
        "W": write_word(int'(f0), lsab_word_t'(f1), lsab_ancill_t'(f2), f3[0]);
        "B":
          for (int i = 0; i < int'(f1); i++)
            write_word(int'(f0), lsab_word_t'(f2 + 32'(i)), lsab_ancill_t'(f3 + 32'(i)), 1'b0);
        "F":
        begin
          repeat (2) @(negedge CLK_n);
          check_full(dev_full, CHANNELS'(f0), "full bits");
        end
        "C":
        begin
          c.start = mvblck_col_t'(f0);
          c.count = mvblck_count_t'(f1);
          c.section = lsab_section_t'(f2);
          exp = '0;
          exp.count_sent = mvblck_count_t'(f3);
          exp.irq = f4[0];
          exp.abrupt_stop = f5[0];
          exp.ancill = lsab_ancill_t'(f6);
          run_block(c, exp);
        end
        default: stop_run($sformatf("unknown line in the stimulus file: %s", line));
      endcase
    end
    $fclose(fd);
    repeat (2) @(negedge CLK_n);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== tests/fill_stimulus.txt ====
# W chan word tag mark : one word, mark 1 sends a lone interrupt strobe before it
# B chan n word tag : n words, word and tag count up from the given values
# F mask : expected full bits once the writes have landed
# C start count section sent irq abrupt tag : block command and expected status
# All fields are hex.
B 2 a 2a000000 100
C 28 a 2 a 0 0 0
# Channel 1 wraps past column 511, then channel 0 comes back unchanged.
B 0 4 c0000000 200
B 1 6 c1000000 300
C 1fc 6 1 6 0 0 0
C 64 4 0 4 0 0 0
# The third word on channel 3 carries the interrupt mark.
B 3 2 33000000 400
W 3 3300abcd 1abcdef 1
B 3 2 33000010 410
C 3c 5 3 3 1 0 1abcdef
C 80 2 3 2 0 0 0
# Only 3 of 8 words are there.
B 0 3 ab000000 500
C c8 8 0 3 0 1 0
# Section 1 fills up to its full mark.
B 1 f bb000000 600
F 2
C 12c f 1 f 0 0 0

// ==== filelist.f ====
logic/lsab_pkg.sv
logic/mvblck_pkg.sv
logic/lsab_ingress.sv
logic/lsab_section.sv
logic/mvblck_todram.sv
logic/lsab_fill_core.sv
tests/lsab_fill_core_assert.sv
tests/tb_lsab_fill_core.sv

// ==== Makefile ====
TOP = tb_lsab_fill_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
